// ==== design/axi_mem_pkg.sv ====
// ########################################################################
// Shared widths, channel structs and state encodings for the AXI4 slave
// memory model. Modules pull these in with a wildcard import.
// ########################################################################
package axi_mem_pkg;

  localparam int axi_id_w      = 4;
  localparam int axi_addr_w    = 16;
  localparam int axi_data_w    = 32;
  localparam int axi_len_w     = 8;
  localparam int axi_strb_w    = axi_data_w / 8;
  localparam int beat_bytes_lg = 2;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // address request, same layout for AW and AR
  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_addr_w-1:0] addr;
    logic [axi_len_w-1:0]  len;
    burst_e                burst;
  } axi_ax_t;

  typedef struct packed {
    logic [axi_data_w-1:0] data;
    logic [axi_strb_w-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [axi_id_w-1:0] id;
    resp_e               resp;
  } axi_b_t;

  typedef struct packed {
    logic [axi_id_w-1:0]   id;
    logic [axi_data_w-1:0] data;
    resp_e                 resp;
    logic                  last;
  } axi_r_t;

  typedef enum logic [1:0] {
    WR_RESET,
    WR_WAIT_ADDR,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_RESET,
    RD_WAIT_ADDR,
    RD_SEND_DATA
  } rd_state_e;

endpackage

// ==== design/axi_burst_addr.sv ====
// ########################################################################
// Next beat address for FIXED, INCR and WRAP bursts. Each channel engine
// feeds it the current address with the latched burst type and length.
// ########################################################################
`timescale 1ns/1ps

module axi_burst_addr
  import axi_mem_pkg::*;
(
  input  logic [axi_addr_w-1:0] addr_i,
  input  burst_e                burst_i,
  input  logic [axi_len_w-1:0]  len_i,
  output logic [axi_addr_w-1:0] next_addr_o
);

  localparam logic [axi_addr_w-1:0] beat_bytes_lp = axi_addr_w'(1 << beat_bytes_lg);

  logic [axi_addr_w-1:0] incr_addr;
  logic [axi_addr_w-1:0] wrap_mask;

  assign incr_addr = addr_i + beat_bytes_lp;

  // span of (len+1) beats, power of two for a legal wrap
  assign wrap_mask = ((axi_addr_w'(len_i) + 1'b1) << beat_bytes_lg) - 1'b1;

  always_comb begin
    case (burst_i)
      BURST_INCR: begin
        next_addr_o = incr_addr;
      end
      BURST_WRAP: begin
        // keep window base, let the offset roll over
        next_addr_o = (addr_i & ~wrap_mask) | (incr_addr & wrap_mask);
        assert (len_i inside {8'd1, 8'd3, 8'd7, 8'd15})
          else $error("wrap burst with illegal len %0d", len_i);
      end
      default: begin
        next_addr_o = addr_i;
      end
    endcase
  end

endmodule

// ==== design/axi_mem_array.sv ====
// ########################################################################
// Word store with byte strobes. Bytes never written read back as the
// matching byte of the fill pattern, tracked by per-byte written flags.
// Callers only present in-range word indices.
// ########################################################################
`timescale 1ns/1ps

module axi_mem_array
  import axi_mem_pkg::*;
#(
  parameter int          mem_els_p     = 256,
  parameter logic [31:0] init_data_p   = 32'hdead_beef,
  localparam int         lg_mem_els_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wr_en_i,
  input  logic [lg_mem_els_lp-1:0] wr_idx_i,
  input  logic [axi_data_w-1:0]    wr_data_i,
  input  logic [axi_strb_w-1:0]    wr_strb_i,
  input  logic [lg_mem_els_lp-1:0] rd_idx_i,
  output logic [axi_data_w-1:0]    rd_data_o
);

  logic [axi_data_w-1:0] mem_r     [mem_els_p];
  logic [axi_strb_w-1:0] written_r [mem_els_p];
  logic [axi_data_w-1:0] fill_data;

  assign fill_data = {(axi_data_w / 32){init_data_p}};

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int b = 0; b < axi_strb_w; b++) begin
        if (wr_strb_i[b]) begin
          mem_r[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  // one flag per byte lane
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < mem_els_p; i++) begin
        written_r[i] <= '0;
      end
    end else if (wr_en_i) begin
      written_r[wr_idx_i] <= written_r[wr_idx_i] | wr_strb_i;
    end
  end

  always_comb begin
    for (int b = 0; b < axi_strb_w; b++) begin
      rd_data_o[b*8 +: 8] = written_r[rd_idx_i][b]
                          ? mem_r[rd_idx_i][b*8 +: 8]
                          : fill_data[b*8 +: 8];
    end
  end

  // engines must filter out-of-range beats before they reach the store
  wr_idx_in_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en_i |-> (int'(wr_idx_i) < mem_els_p))
    else $error("array write index %0d beyond %0d words", wr_idx_i, mem_els_p);

endmodule

// ==== design/axi_write_engine.sv ====
// ########################################################################
// AW/W/B channel FSM. Accepts one write burst at a time, issues strobed
// array writes per beat and answers with a single B response.
// ########################################################################
`timescale 1ns/1ps

module axi_write_engine
  import axi_mem_pkg::*;
#(
  parameter int  mem_els_p     = 256,
  localparam int lg_mem_els_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  axi_ax_t                  aw_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,

  input  axi_w_t                   w_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,

  output axi_b_t                   b_o,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,

  output logic                     wr_en_o,
  output logic [lg_mem_els_lp-1:0] wr_idx_o,
  output logic [axi_data_w-1:0]    wr_data_o,
  output logic [axi_strb_w-1:0]    wr_strb_o
);

  wr_state_e             wr_state_r;
  wr_state_e             wr_state_n;
  axi_ax_t               aw_r;
  logic [axi_len_w-1:0]  beat_cnt_r;
  logic                  err_r;
  logic [axi_addr_w-1:0] next_addr;
  logic                  in_range;
  logic                  aw_fire;
  logic                  w_fire;

  assign aw_fire = aw_valid_i & aw_ready_o;
  assign w_fire  = w_valid_i & w_ready_o;

  // word index of the running address
  assign in_range = int'(aw_r.addr[axi_addr_w-1:beat_bytes_lg]) < mem_els_p;

  axi_burst_addr addr_gen (
    .addr_i      (aw_r.addr),
    .burst_i     (aw_r.burst),
    .len_i       (aw_r.len),
    .next_addr_o (next_addr)
  );

  always_comb begin
    wr_state_n = wr_state_r;
    case (wr_state_r)
      WR_RESET: begin
        wr_state_n = WR_WAIT_ADDR;
      end
      WR_WAIT_ADDR: begin
        if (aw_valid_i) begin
          wr_state_n = WR_WAIT_DATA;
        end
      end
      WR_WAIT_DATA: begin
        if (w_valid_i & w_i.last) begin
          wr_state_n = WR_RESP;
        end
      end
      WR_RESP: begin
        if (b_ready_i) begin
          wr_state_n = WR_WAIT_ADDR;
        end
      end
      default: begin
        wr_state_n = WR_RESET;
      end
    endcase
  end

  assign aw_ready_o = (wr_state_r == WR_WAIT_ADDR);
  assign w_ready_o  = (wr_state_r == WR_WAIT_DATA);
  assign b_valid_o  = (wr_state_r == WR_RESP);

  assign b_o.id   = aw_r.id;
  assign b_o.resp = err_r ? RESP_SLVERR : RESP_OKAY;

  // out-of-range beats are dropped here
  assign wr_en_o   = w_fire & in_range;
  assign wr_idx_o  = aw_r.addr[beat_bytes_lg +: lg_mem_els_lp];
  assign wr_data_o = w_i.data;
  assign wr_strb_o = w_i.strb;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_r <= WR_RESET;
      beat_cnt_r <= '0;
      err_r      <= 1'b0;
    end else begin
      wr_state_r <= wr_state_n;
      if (aw_fire) begin
        beat_cnt_r <= '0;
        err_r      <= 1'b0;
      end else if (w_fire) begin
        beat_cnt_r <= beat_cnt_r + 1'b1;
        if (!in_range) begin
          err_r <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      aw_r <= aw_i;
    end else if (w_fire) begin
      aw_r.addr <= next_addr;
    end
  end

  w_last_on_len_a: assert property (@(posedge clk_i) disable iff (reset_i)
    w_fire |-> (w_i.last == (beat_cnt_r == aw_r.len)))
    else $error("wlast on beat %0d, burst len %0d", beat_cnt_r, aw_r.len);

endmodule

// ==== design/axi_read_engine.sv ====
// ########################################################################
// AR/R channel FSM. Latches one read burst and streams its beats from the
// array, holding each beat until the master takes it.
// ########################################################################
`timescale 1ns/1ps

module axi_read_engine
  import axi_mem_pkg::*;
#(
  parameter int          mem_els_p     = 256,
  parameter logic [31:0] init_data_p   = 32'hdead_beef,
  localparam int         lg_mem_els_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1
)
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  axi_ax_t                  ar_i,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,

  output axi_r_t                   r_o,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,

  output logic [lg_mem_els_lp-1:0] rd_idx_o,
  input  logic [axi_data_w-1:0]    rd_data_i
);

  rd_state_e             rd_state_r;
  rd_state_e             rd_state_n;
  axi_ax_t               ar_r;
  logic [axi_len_w-1:0]  beat_cnt_r;
  logic [axi_addr_w-1:0] next_addr;
  logic [axi_data_w-1:0] fill_data;
  logic                  in_range;
  logic                  ar_fire;
  logic                  r_fire;

  assign ar_fire   = ar_valid_i & ar_ready_o;
  assign r_fire    = r_valid_o & r_ready_i;
  assign fill_data = {(axi_data_w / 32){init_data_p}};
  assign in_range  = int'(ar_r.addr[axi_addr_w-1:beat_bytes_lg]) < mem_els_p;

  axi_burst_addr addr_gen (
    .addr_i      (ar_r.addr),
    .burst_i     (ar_r.burst),
    .len_i       (ar_r.len),
    .next_addr_o (next_addr)
  );

  always_comb begin
    rd_state_n = rd_state_r;
    case (rd_state_r)
      RD_RESET: begin
        rd_state_n = RD_WAIT_ADDR;
      end
      RD_WAIT_ADDR: begin
        if (ar_valid_i) begin
          rd_state_n = RD_SEND_DATA;
        end
      end
      RD_SEND_DATA: begin
        if (r_ready_i & r_o.last) begin
          rd_state_n = RD_WAIT_ADDR;
        end
      end
      default: begin
        rd_state_n = RD_RESET;
      end
    endcase
  end

  assign ar_ready_o = (rd_state_r == RD_WAIT_ADDR);
  assign r_valid_o  = (rd_state_r == RD_SEND_DATA);
  assign rd_idx_o   = ar_r.addr[beat_bytes_lg +: lg_mem_els_lp];

  // out of range beats carry the fill word
  assign r_o.id   = ar_r.id;
  assign r_o.data = in_range ? rd_data_i : fill_data;
  assign r_o.resp = in_range ? RESP_OKAY : RESP_SLVERR;
  assign r_o.last = (beat_cnt_r == ar_r.len);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_state_r <= RD_RESET;
      beat_cnt_r <= '0;
    end else begin
      rd_state_r <= rd_state_n;
      if (ar_fire) begin
        beat_cnt_r <= '0;
      end else if (r_fire) begin
        beat_cnt_r <= beat_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      ar_r <= ar_i;
    end else if (r_fire) begin
      ar_r.addr <= next_addr;
    end
  end

  r_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)))
    else $error("read beat changed while stalled");

endmodule

// ==== design/axi_mem_top.sv ====
// ########################################################################
// AXI4 slave memory model. Independent write and read engines share one
// word array; instantiate with the word count and the fill pattern.
// ########################################################################
`timescale 1ns/1ps

module axi_mem_top
  import axi_mem_pkg::*;
#(
  parameter int          mem_els_p     = 256,
  parameter logic [31:0] init_data_p   = 32'hdead_beef,
  localparam int         lg_mem_els_lp = (mem_els_p > 1) ? $clog2(mem_els_p) : 1
)
(
  input  logic    clk_i,
  input  logic    reset_i,

  input  axi_ax_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,

  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,

  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,

  input  axi_ax_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,

  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  logic                     wr_en;
  logic [lg_mem_els_lp-1:0] wr_idx;
  logic [axi_data_w-1:0]    wr_data;
  logic [axi_strb_w-1:0]    wr_strb;
  logic [lg_mem_els_lp-1:0] rd_idx;
  logic [axi_data_w-1:0]    rd_data;

  axi_write_engine #(
    .mem_els_p (mem_els_p)
  ) wr_eng (
    .clk_i, .reset_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .wr_en_o   (wr_en),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb)
  );

  axi_read_engine #(
    .mem_els_p   (mem_els_p),
    .init_data_p (init_data_p)
  ) rd_eng (
    .clk_i, .reset_i,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i,
    .rd_idx_o  (rd_idx),
    .rd_data_i (rd_data)
  );

  axi_mem_array #(
    .mem_els_p   (mem_els_p),
    .init_data_p (init_data_p)
  ) mem (
    .clk_i, .reset_i,
    .wr_en_i   (wr_en),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data)
  );

endmodule

// ==== verification/axi_mem_tb.sv ====
// ########################################################################
// Testbench for the AXI4 slave memory. Replays the transactions of the
// tests file with random ready drops and W gaps and checks every response.
// ########################################################################
`timescale 1ns/1ps

module axi_mem_tb
  import axi_mem_pkg::*;
();

  typedef logic [8*20-1:0] name_t;

  logic    clk_i;
  logic    reset_i;
  axi_ax_t aw_i;
  logic    aw_valid_i;
  logic    aw_ready_o;
  axi_w_t  w_i;
  logic    w_valid_i;
  logic    w_ready_o;
  axi_b_t  b_o;
  logic    b_valid_o;
  logic    b_ready_i;
  axi_ax_t ar_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  axi_r_t  r_o;
  logic    r_valid_o;
  logic    r_ready_i;

  // loaded transactions with all beats in one flat queue
  axi_ax_t     rec_ax[$];
  name_t       rec_name[$];
  logic [7:0]  rec_kind[$];
  int          rec_first[$];
  logic [1:0]  rec_bresp[$];
  logic [31:0] beat_data[$];
  logic [3:0]  beat_aux[$];

  logic [31:0] rand_state;
  int          cycle_cnt;
  int          cycle_limit;
  logic        limit_set;
  logic        load_ok;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;

  axi_mem_top #(
    .mem_els_p   (256),
    .init_data_p (32'hdead_beef)
  ) dut (
    .clk_i, .reset_i,
    .aw_i, .aw_valid_i, .aw_ready_o,
    .w_i, .w_valid_i, .w_ready_o,
    .b_o, .b_valid_o, .b_ready_i,
    .ar_i, .ar_valid_i, .ar_ready_o,
    .r_o, .r_valid_o, .r_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit_set && cycle_cnt >= cycle_limit) begin
      $display("run stopped after %0d cycles with tests still pending", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  task automatic check_value(input name_t name, input string what,
                             input logic [63:0] exp_v, input logic [63:0] act_v);
    assert (exp_v == act_v)
      else begin
        $display("error: test %0s %0s expected %0h actual %0h", name, what, exp_v, act_v);
        test_errs++;
      end
  endtask

  task automatic finish_test(input name_t name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("test %0s passed", name);
    end else begin
      fail_cnt++;
      $display("test %0s failed with %0d errors", name, test_errs);
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    int          beats_left;
    logic        want_resp;
    string       line;
    logic [7:0]  kind_v;
    name_t       name_v;
    logic [31:0] id_v;
    logic [31:0] addr_v;
    logic [31:0] len_v;
    logic [31:0] burst_v;
    logic [31:0] data_v;
    logic [31:0] aux_v;
    axi_ax_t     ax;
    beats_left = 0;
    want_resp  = 1'b0;
    fd = $fopen("verification/axi_mem_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/axi_mem_tests.txt");
      load_ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          n = 0;
        end else if (beats_left > 0) begin
          n = $sscanf(line, "%h %h", data_v, aux_v);
          if (n != 2) begin
            $display("the tests file holds a beat line without two fields");
            load_ok = 1'b0;
          end
          beat_data.push_back(data_v);
          beat_aux.push_back(aux_v[3:0]);
          beats_left--;
        end else if (want_resp) begin
          n = $sscanf(line, "%h", aux_v);
          if (n != 1) begin
            $display("the tests file holds a response line without a value");
            load_ok = 1'b0;
          end
          rec_bresp.push_back(aux_v[1:0]);
          want_resp = 1'b0;
        end else begin
          n = $sscanf(line, "%s %s %h %h %h %h", kind_v, name_v, id_v, addr_v, len_v, burst_v);
          if (n != 6 || (kind_v != "W" && kind_v != "R")) begin
            $display("the tests file holds a line that is not a valid record");
            load_ok = 1'b0;
          end else begin
            ax.id    = id_v[axi_id_w-1:0];
            ax.addr  = addr_v[axi_addr_w-1:0];
            ax.len   = len_v[axi_len_w-1:0];
            ax.burst = burst_e'(burst_v[1:0]);
            rec_ax.push_back(ax);
            rec_name.push_back(name_v);
            rec_kind.push_back(kind_v);
            rec_first.push_back(beat_data.size());
            beats_left  = int'(ax.len) + 1;
            want_resp   = (kind_v == "W");
            cycle_limit = cycle_limit + 4 * (int'(ax.len) + 1) + 40;
            if (kind_v == "R") begin
              rec_bresp.push_back(2'b00);
            end
          end
        end
      end
      $fclose(fd);
      if (rec_ax.size() == 0) begin
        $display("the tests file holds no transactions");
        load_ok = 1'b0;
      end
      if (beats_left != 0 || want_resp) begin
        $display("the tests file ends in the middle of a transaction");
        load_ok = 1'b0;
      end
    end
  endtask

  // outputs in the first cycle with reset low and one cycle later
  task automatic check_reset();
    #1;
    check_value("reset_state", "aw_ready", 0, aw_ready_o);
    check_value("reset_state", "ar_ready", 0, ar_ready_o);
    check_value("reset_state", "b_valid", 0, b_valid_o);
    check_value("reset_state", "r_valid", 0, r_valid_o);
    check_value("reset_state", "w_ready", 0, w_ready_o);
    @(negedge clk_i);
    #1;
    check_value("reset_state", "aw_ready a cycle later", 1, aw_ready_o);
    check_value("reset_state", "ar_ready a cycle later", 1, ar_ready_o);
    @(negedge clk_i);
  endtask

  task automatic run_write(input int r);
    int          beat;
    int          idx;
    logic        done;
    logic [31:0] rnd;
    beat = 0;
    done = 1'b0;
    aw_i = rec_ax[r];
    aw_valid_i = 1'b1;
    #1;
    while (!aw_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    while (beat <= int'(rec_ax[r].len)) begin
      idx = rec_first[r] + beat;
      rnd = next_random();
      w_valid_i = (rnd[31:30] != 2'b00);
      w_i.data  = beat_data[idx];
      w_i.strb  = beat_aux[idx];
      w_i.last  = (beat == int'(rec_ax[r].len));
      #1;
      if (w_valid_i && w_ready_o) begin
        beat++;
      end
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    // B is the back-pressure point
    while (!done) begin
      rnd = next_random();
      b_ready_i = (rnd[31:30] != 2'b00);
      #1;
      if (b_valid_o && b_ready_i) begin
        check_value(rec_name[r], "bid", rec_ax[r].id, b_o.id);
        check_value(rec_name[r], "bresp", rec_bresp[r], b_o.resp);
        done = 1'b1;
      end
      @(negedge clk_i);
    end
    b_ready_i = 1'b0;
  endtask

  task automatic run_read(input int r);
    int          beat;
    int          idx;
    logic        held;
    axi_r_t      held_beat;
    logic [31:0] rnd;
    beat = 0;
    held = 1'b0;
    held_beat = '0;
    ar_i = rec_ax[r];
    ar_valid_i = 1'b1;
    #1;
    while (!ar_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    ar_valid_i = 1'b0;
    while (beat <= int'(rec_ax[r].len)) begin
      idx = rec_first[r] + beat;
      rnd = next_random();
      r_ready_i = (rnd[31:30] != 2'b00);
      #1;
      if (held) begin
        check_value(rec_name[r], $sformatf("stalled beat %0d", beat), held_beat, r_o);
      end
      held = 1'b0;
      if (r_valid_o && r_ready_i) begin
        check_value(rec_name[r], $sformatf("beat %0d data", beat), beat_data[idx], r_o.data);
        check_value(rec_name[r], $sformatf("beat %0d resp", beat), beat_aux[idx][1:0], r_o.resp);
        check_value(rec_name[r], $sformatf("beat %0d last", beat),
                    beat == int'(rec_ax[r].len), r_o.last);
        check_value(rec_name[r], $sformatf("beat %0d rid", beat), rec_ax[r].id, r_o.id);
        beat++;
      end else if (r_valid_o) begin
        held = 1'b1;
        held_beat = r_o;
      end
      @(negedge clk_i);
    end
    r_ready_i = 1'b0;
  endtask

  initial begin
    int r;
    reset_i    = 1'b1;
    aw_i       = '0;
    aw_valid_i = 1'b0;
    w_i        = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b0;
    ar_i       = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    rand_state  = 32'd97;
    cycle_cnt   = 0;
    cycle_limit = 0;
    limit_set   = 1'b0;
    load_ok     = 1'b1;
    pass_cnt    = 0;
    fail_cnt    = 0;
    load_tests();
    limit_set = load_ok;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_errs = 0;
    check_reset();
    finish_test("reset_state");
    if (load_ok) begin
      for (r = 0; r < rec_ax.size(); r++) begin
        test_errs = 0;
        if (rec_kind[r] == "W") begin
          run_write(r);
        end else begin
          run_read(r);
        end
        finish_test(rec_name[r]);
      end
    end else begin
      fail_cnt++;
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
design/axi_mem_pkg.sv
design/axi_burst_addr.sv
design/axi_mem_array.sv
design/axi_write_engine.sv
design/axi_read_engine.sv
design/axi_mem_top.sv
verification/axi_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module axi_mem_tb \
  -f src.f -o axi_mem_sim || exit 1
./obj_dir/axi_mem_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0

// ==== verification/axi_mem_tests.txt ====
# W name id addr len burst, then one "data strb" line per beat, then the expected B resp
# R name id addr len burst, then one "data resp" line per beat; burst 0/1/2, resp 0 or 2
W incr8_wr 3 0040 07 1
11110000 f
11110001 f
11110002 f
11110003 f
11110004 f
11110005 f
11110006 f
11110007 f
0
R incr8_rd 5 0040 07 1
11110000 0
11110001 0
11110002 0
11110003 0
11110004 0
11110005 0
11110006 0
11110007 0
W strobe_wr 1 0100 01 1
12345678 3
aabbccdd c
0
R strobe_rd 2 0100 02 1
dead5678 0
aabbbeef 0
deadbeef 0
W wrap_wr 4 0208 03 2
22220002 f
22220003 f
22220000 f
22220001 f
0
R wrap_rd 6 0204 03 2
22220001 0
22220002 0
22220003 0
22220000 0
W fixed_wr 7 0300 03 0
01010101 f
02020202 f
03030303 f
44444444 3
0
R fixed_rd 8 0300 00 1
03034444 0
W oor_wr 9 0400 01 1
55555555 f
66666666 f
2
R alias_rd a 0000 01 1
deadbeef 0
deadbeef 0
R oor_rd b 03fc 02 1
deadbeef 0
deadbeef 2
deadbeef 2
